/* muldiv_cfg_pkg.sv */
package muldiv_cfg_pkg;

    // lanes handled together for one warp request
    localparam int NUM_THREADS  = 4;

    localparam int NW_BITS      = 2;   // up to four warps
    localparam int NR_BITS      = 5;   // 32 architectural registers

    // register stages between the multiplier inputs and the pipeline end
    localparam int LATENCY_IMUL = 3;

    localparam int DIV_STEPS    = 32;  // one quotient bit per iteration

    // lane operand and lane result
    typedef logic [31:0]            word_t;

    typedef logic [NW_BITS-1:0]     wid_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [NR_BITS-1:0]     rd_t;
    typedef logic [31:0]            pc_t;

endpackage

/* muldiv_types_pkg.sv */
package muldiv_types_pkg;

    import muldiv_cfg_pkg::*;

    // bit 2 set means the op belongs to the divide class
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,   // bit 0 marks the unsigned divides
        REM    = 3'b110,   // bit 1 marks the remainders
        REMU   = 3'b111
    } muldiv_op_t;

    // everything that rides along with a request and comes back with the result
    typedef struct packed {
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
        rd_t    rd;
        logic   wb;
    } muldiv_tag_t;

    typedef struct packed {
        muldiv_op_t              op;
        muldiv_tag_t             tag;
        word_t [NUM_THREADS-1:0] a;
        word_t [NUM_THREADS-1:0] b;
    } muldiv_req_t;

    typedef struct packed {
        muldiv_tag_t             tag;
        word_t [NUM_THREADS-1:0] data;
    } muldiv_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } div_state_t;

endpackage

/* mul_pipe.sv */
module mul_pipe (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    in_valid,
    input  muldiv_types_pkg::muldiv_op_t                            in_op,
    input  muldiv_types_pkg::muldiv_tag_t                           in_tag,
    input  muldiv_cfg_pkg::word_t [muldiv_cfg_pkg::NUM_THREADS-1:0] a,
    input  muldiv_cfg_pkg::word_t [muldiv_cfg_pkg::NUM_THREADS-1:0] b,
    input  logic                                                    advance,
    output logic                                                    out_valid,
    output muldiv_types_pkg::muldiv_rsp_t                           out
);

    import muldiv_cfg_pkg::*;
    import muldiv_types_pkg::*;

    typedef logic [63:0] prod_t;

    logic                    is_mulh;
    logic                    sign_a;
    logic                    sign_b;
    prod_t [NUM_THREADS-1:0] prod;

    logic [LATENCY_IMUL-1:0] vld_q;
    logic [LATENCY_IMUL-1:0] mulh_q;
    muldiv_tag_t             tag_q  [LATENCY_IMUL];
    prod_t [NUM_THREADS-1:0] prod_q [LATENCY_IMUL];

    word_t [NUM_THREADS-1:0] res;

    assign is_mulh = (in_op != MUL);
    assign sign_a  = (in_op != MULHU);                     // MULHSU keeps a signed
    assign sign_b  = (in_op == MUL) || (in_op == MULH);

    for (genvar i = 0; i < NUM_THREADS; i++) begin : g_lane
        logic signed [32:0] op_a;
        logic signed [32:0] op_b;

        // the extra top bit turns both signed and unsigned operands into signed ones
        assign op_a    = {sign_a & a[i][31], a[i]};
        assign op_b    = {sign_b & b[i][31], b[i]};
        assign prod[i] = op_a * op_b;   // low 64 bits of the 66-bit product

        assign res[i] = mulh_q[LATENCY_IMUL-1] ? prod_q[LATENCY_IMUL-1][i][63:32]
                                               : prod_q[LATENCY_IMUL-1][i][31:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else if (advance) begin
            vld_q[0] <= in_valid;
            for (int s = 1; s < LATENCY_IMUL; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    // every stage holds while the output register is stalled on a valid result
    always_ff @(posedge clk) begin
        if (advance) begin
            tag_q[0]  <= in_tag;
            mulh_q[0] <= is_mulh;
            prod_q[0] <= prod;
            for (int s = 1; s < LATENCY_IMUL; s++) begin
                tag_q[s]  <= tag_q[s-1];
                mulh_q[s] <= mulh_q[s-1];
                prod_q[s] <= prod_q[s-1];
            end
        end
    end

    assign out_valid = vld_q[LATENCY_IMUL-1];
    assign out.tag   = tag_q[LATENCY_IMUL-1];
    assign out.data  = res;

endmodule

/* serial_div.sv */
module serial_div (
    input  logic                                                    clk,
    input  logic                                                    rst,
    input  logic                                                    in_valid,
    output logic                                                    in_ready,
    input  muldiv_types_pkg::muldiv_op_t                            in_op,
    input  muldiv_types_pkg::muldiv_tag_t                           in_tag,
    input  muldiv_cfg_pkg::word_t [muldiv_cfg_pkg::NUM_THREADS-1:0] a,
    input  muldiv_cfg_pkg::word_t [muldiv_cfg_pkg::NUM_THREADS-1:0] b,
    output logic                                                    out_valid,
    input  logic                                                    grant,
    output muldiv_types_pkg::muldiv_rsp_t                           out
);

    import muldiv_cfg_pkg::*;
    import muldiv_types_pkg::*;

    div_state_t                     state;
    logic [$clog2(DIV_STEPS+1)-1:0] step_cnt;   // 0 is the setup cycle
    logic                           accept;
    logic                           setup;
    logic                           last_step;

    muldiv_tag_t             tag_q;
    logic                    is_rem_q;
    logic                    is_signed_q;
    word_t [NUM_THREADS-1:0] a_q;       // raw dividend that the corner cases also need
    word_t [NUM_THREADS-1:0] b_q;
    word_t [NUM_THREADS-1:0] den_q;     // divisor magnitude
    word_t [NUM_THREADS-1:0] quo_q;     // starts as the dividend magnitude
    word_t [NUM_THREADS-1:0] rem_q;
    logic [NUM_THREADS-1:0]  neg_quo_q;
    logic [NUM_THREADS-1:0]  neg_rem_q;
    logic [NUM_THREADS-1:0]  div_zero_q;
    logic [NUM_THREADS-1:0]  ovf_q;

    logic [NUM_THREADS-1:0]  neg_a;
    logic [NUM_THREADS-1:0]  neg_b;
    word_t [NUM_THREADS-1:0] quo_nxt;
    word_t [NUM_THREADS-1:0] rem_nxt;

    assign in_ready  = (state == IDLE);
    assign accept    = in_valid & in_ready;
    assign setup     = (state == BUSY) && (step_cnt == '0);
    assign last_step = (state == BUSY) && (step_cnt == DIV_STEPS);
    assign out_valid = (state == DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state    <= BUSY;
                        step_cnt <= '0;
                    end
                end
                BUSY: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (last_step) begin
                        state <= DONE;
                    end
                end
                DONE: begin
                    if (grant) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // one restoring shift-subtract step per lane
    always_comb begin
        logic [32:0] shifted;
        for (int i = 0; i < NUM_THREADS; i++) begin
            neg_a[i] = is_signed_q & a_q[i][31];
            neg_b[i] = is_signed_q & b_q[i][31];
            shifted  = {rem_q[i], quo_q[i][31]};
            if (shifted >= {1'b0, den_q[i]}) begin
                rem_nxt[i] = 32'(shifted - {1'b0, den_q[i]});
                quo_nxt[i] = {quo_q[i][30:0], 1'b1};
            end else begin
                rem_nxt[i] = shifted[31:0];
                quo_nxt[i] = {quo_q[i][30:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_q       <= in_tag;
            is_rem_q    <= in_op[1];
            is_signed_q <= ~in_op[0];
            a_q         <= a;
            b_q         <= b;
        end
        if (setup) begin
            for (int i = 0; i < NUM_THREADS; i++) begin
                quo_q[i]      <= neg_a[i] ? -a_q[i] : a_q[i];
                den_q[i]      <= neg_b[i] ? -b_q[i] : b_q[i];
                rem_q[i]      <= '0;
                neg_quo_q[i]  <= neg_a[i] ^ neg_b[i];
                neg_rem_q[i]  <= neg_a[i];   // remainder takes the dividend's sign
                div_zero_q[i] <= (b_q[i] == '0);
                ovf_q[i]      <= is_signed_q && (a_q[i] == 32'h8000_0000) && (b_q[i] == '1);
            end
        end else if (state == BUSY) begin
            quo_q <= quo_nxt;
            rem_q <= rem_nxt;
        end
    end

    always_comb begin
        word_t quo;
        word_t rem;
        out.tag = tag_q;
        for (int i = 0; i < NUM_THREADS; i++) begin
            quo = neg_quo_q[i] ? -quo_q[i] : quo_q[i];
            rem = neg_rem_q[i] ? -rem_q[i] : rem_q[i];
            if (div_zero_q[i]) begin
                quo = '1;
                rem = a_q[i];
            end else if (ovf_q[i]) begin
                quo = a_q[i];
                rem = '0;
            end
            out.data[i] = is_rem_q ? rem : quo;
        end
    end

endmodule

/* rsp_arbiter.sv */
module rsp_arbiter (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          mul_valid,
    input  muldiv_types_pkg::muldiv_rsp_t mul_rsp,
    output logic                          advance,

    input  logic                          div_valid,
    input  muldiv_types_pkg::muldiv_rsp_t div_rsp,
    output logic                          grant,

    output logic                          rsp_valid,
    output muldiv_types_pkg::muldiv_rsp_t rsp,
    input  logic                          rsp_ready
);

    logic stall;
    logic sel_valid;

    // the output register is full and the consumer does not take it
    assign stall = rsp_valid & ~rsp_ready;

    // the multiply pipeline may also move when its last stage is empty
    assign advance = ~stall | ~mul_valid;

    assign grant     = ~stall & ~mul_valid;   // multiplier wins every conflict
    assign sel_valid = mul_valid | div_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (~stall) begin
            rsp_valid <= sel_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (~stall) begin
            rsp <= mul_valid ? mul_rsp : div_rsp;
        end
    end

endmodule

/* muldiv_unit.sv */
module muldiv_unit (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  muldiv_types_pkg::muldiv_req_t req,
    output logic                          rsp_valid,
    input  logic                          rsp_ready,
    output muldiv_types_pkg::muldiv_rsp_t rsp
);

    import muldiv_types_pkg::*;

    logic        is_div;
    logic        mul_req_valid;
    logic        div_req_valid;
    logic        div_req_ready;
    logic        advance;
    logic        grant;
    logic        mul_valid;
    logic        div_valid;
    muldiv_rsp_t mul_rsp;
    muldiv_rsp_t div_rsp;

    assign is_div        = req.op[2];
    assign mul_req_valid = req_valid & ~is_div;
    assign div_req_valid = req_valid & is_div;
    assign req_ready     = is_div ? div_req_ready : advance;

    mul_pipe i_mul_pipe (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (mul_req_valid),
        .in_op     (req.op),
        .in_tag    (req.tag),
        .a         (req.a),
        .b         (req.b),
        .advance   (advance),
        .out_valid (mul_valid),
        .out       (mul_rsp)
    );

    serial_div i_serial_div (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (div_req_valid),
        .in_ready  (div_req_ready),
        .in_op     (req.op),
        .in_tag    (req.tag),
        .a         (req.a),
        .b         (req.b),
        .out_valid (div_valid),
        .grant     (grant),
        .out       (div_rsp)
    );

    rsp_arbiter i_rsp_arbiter (
        .clk       (clk),
        .rst       (rst),
        .mul_valid (mul_valid),
        .mul_rsp   (mul_rsp),
        .advance   (advance),
        .div_valid (div_valid),
        .div_rsp   (div_rsp),
        .grant     (grant),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

endmodule

/* muldiv_assertions.sv */
module muldiv_assertions (
    input logic                          clk,
    input logic                          rst,
    input logic                          req_valid,
    input logic                          req_ready,
    input muldiv_types_pkg::muldiv_req_t req,
    input logic                          rsp_valid,
    input logic                          rsp_ready,
    input muldiv_types_pkg::muldiv_rsp_t rsp,
    input logic                          div_valid,
    input logic                          grant
);

    timeunit 1ns;
    timeprecision 100ps;

    logic div_held;       // a divide stays in the divider until its result is granted
    int   failures = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            div_held <= 1'b0;
        end else if (req_valid && req_ready && req.op[2]) begin
            div_held <= 1'b1;
        end else if (div_valid && grant) begin
            div_held <= 1'b0;
        end
    end

    a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            failures++;
            $error("rsp or rsp_valid changed while the consumer stalled");
        end

    a_rsp_reset: assert property (@(posedge clk) rst |=> !rsp_valid)
        else begin
            failures++;
            $error("rsp_valid high after a reset cycle");
        end

    a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> req_ready)
        else begin
            failures++;
            $error("req_ready low in the first cycle after reset");
        end

    // the divider holds one request at a time
    a_one_divide: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready && req.op[2] |-> !div_held)
        else begin
            failures++;
            $error("divide accepted while another divide is held");
        end

endmodule

/* muldiv_checker.sv */
module muldiv_checker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rsp_valid,
    input  logic                          rsp_ready,
    input  muldiv_types_pkg::muldiv_rsp_t rsp,
    input  logic                          push,
    input  muldiv_types_pkg::muldiv_rsp_t push_rsp,
    output int                            n_checked,
    output int                            n_errors,
    output int                            n_pending,
    output int                            n_overtaken
);

    timeunit 1ns;
    timeprecision 100ps;

    import muldiv_cfg_pkg::*;
    import muldiv_types_pkg::*;

    muldiv_rsp_t expected [pc_t];   // responses still owed and keyed by the unique PC
    int          checked = 0;
    int          errors = 0;
    int          overtaken = 0;
    pc_t         newest_pc = '0;

    assign n_checked   = checked;
    assign n_errors    = errors;
    assign n_overtaken = overtaken;

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act, input pc_t pc);
        if (exp !== act) begin
            $display("[FAIL] %s (pc %h): expected %h, got %h", name, pc, exp, act);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        muldiv_rsp_t e;
        if (!rst && rsp_valid && rsp_ready) begin
            if (expected.exists(rsp.tag.pc)) begin
                e = expected[rsp.tag.pc];
                check_field("rsp.tag.wid", 32'(e.tag.wid), 32'(rsp.tag.wid), rsp.tag.pc);
                check_field("rsp.tag.tmask", 32'(e.tag.tmask), 32'(rsp.tag.tmask), rsp.tag.pc);
                check_field("rsp.tag.rd", 32'(e.tag.rd), 32'(rsp.tag.rd), rsp.tag.pc);
                check_field("rsp.tag.wb", 32'(e.tag.wb), 32'(rsp.tag.wb), rsp.tag.pc);
                for (int i = 0; i < NUM_THREADS; i++) begin
                    check_field($sformatf("rsp.data[%0d]", i), e.data[i], rsp.data[i],
                                rsp.tag.pc);
                end
                if (rsp.tag.pc < newest_pc) begin
                    overtaken++;   // a later request came back before this one
                end else begin
                    newest_pc = rsp.tag.pc;
                end
                expected.delete(rsp.tag.pc);
                checked++;
            end else begin
                $display("a response came back with pc %h, which no pending request has",
                         rsp.tag.pc);
                errors++;
            end
        end
        if (push) begin
            expected[push_rsp.tag.pc] = push_rsp;
        end
        n_pending = expected.num();
    end

endmodule

/* tb_muldiv.sv */
module tb_muldiv;

    timeunit 1ns;
    timeprecision 100ps;

    import muldiv_cfg_pkg::*;
    import muldiv_types_pkg::*;

    localparam int NUM_REQS   = 20 + 24 + 20 + 30 + 16;
    localparam int MAX_CYCLES = NUM_REQS * (DIV_STEPS + LATENCY_IMUL + 8) * 4;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    muldiv_req_t req;
    logic        rsp_valid;
    logic        rsp_ready;
    muldiv_rsp_t rsp;
    logic        push;
    muldiv_rsp_t push_rsp;
    logic        bp_en;          // random back-pressure on rsp_ready
    int          n_checked;
    int          n_errors;
    int          n_pending;
    int          n_overtaken;
    int          lost = 0;
    int          order_errors = 0;
    integer      seed = 32'h100412d8;
    pc_t         next_pc = 32'h0000_1000;

    always #50 clk = ~clk;

    always @(posedge clk) begin
        #10;
        rsp_ready = bp_en ? (($random(seed) & 3) != 0) : 1'b1;
    end

    muldiv_unit i_muldiv_unit (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    muldiv_checker i_muldiv_checker (
        .clk         (clk),
        .rst         (rst),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp         (rsp),
        .push        (push),
        .push_rsp    (push_rsp),
        .n_checked   (n_checked),
        .n_errors    (n_errors),
        .n_pending   (n_pending),
        .n_overtaken (n_overtaken)
    );

    bind muldiv_unit muldiv_assertions i_muldiv_assertions (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .div_valid (div_valid),
        .grant     (grant)
    );

    // RISC-V M-extension results for each lane
    function automatic muldiv_rsp_t expected_rsp(muldiv_req_t r);
        muldiv_rsp_t e;
        logic [63:0] xa;
        logic [63:0] xb;
        logic [63:0] p;
        int          sa;
        int          sb;
        e.tag = r.tag;
        for (int i = 0; i < NUM_THREADS; i++) begin
            xa = (r.op == MULHU) ? {32'b0, r.a[i]} : {{32{r.a[i][31]}}, r.a[i]};
            xb = (r.op == MULHU || r.op == MULHSU) ? {32'b0, r.b[i]} : {{32{r.b[i][31]}}, r.b[i]};
            p  = xa * xb;   // the low 64 bits are exact for every sign mix
            sa = r.a[i];
            sb = r.b[i];
            case (r.op)
                MUL: e.data[i] = p[31:0];
                DIV, REM: begin
                    if (r.b[i] == '0) begin
                        e.data[i] = (r.op == DIV) ? '1 : r.a[i];
                    end else if (r.a[i] == 32'h8000_0000 && r.b[i] == '1) begin
                        e.data[i] = (r.op == DIV) ? r.a[i] : '0;
                    end else begin
                        e.data[i] = (r.op == DIV) ? sa / sb : sa % sb;
                    end
                end
                DIVU: e.data[i] = (r.b[i] == '0) ? '1 : r.a[i] / r.b[i];
                REMU: e.data[i] = (r.b[i] == '0) ? r.a[i] : r.a[i] % r.b[i];
                default: e.data[i] = p[63:32];
            endcase
        end
        return e;
    endfunction

    function automatic int total_errors();
        return n_errors + lost + order_errors + i_muldiv_unit.i_muldiv_assertions.failures;
    endfunction

    task automatic fill(output word_t [NUM_THREADS-1:0] v, input word_t set_bits,
                        input bit narrow);
        for (int i = 0; i < NUM_THREADS; i++) begin
            v[i] = word_t'($random(seed)) | set_bits;
            if (narrow) begin
                v[i] = v[i] >> ($random(seed) & 31);   // small divisors give wide quotients
            end
        end
    endtask

    // called 10 ns after a rising edge and returns 10 ns after the accepting edge
    task automatic send(input muldiv_op_t op, input word_t [NUM_THREADS-1:0] a,
                        input word_t [NUM_THREADS-1:0] b);
        logic taken;
        req.op        = op;
        req.tag.wid   = wid_t'($random(seed));
        req.tag.tmask = tmask_t'($random(seed));
        req.tag.pc    = next_pc;
        req.tag.rd    = rd_t'($random(seed));
        req.tag.wb    = 1'($random(seed));
        req.a         = a;
        req.b         = b;
        req_valid     = 1'b1;
        next_pc       = next_pc + 4;
        taken         = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken    = req_ready;
            push     = req_ready;
            push_rsp = expected_rsp(req);
            @(posedge clk);
            #10;
            push = 1'b0;
        end
        req_valid = 1'b0;
    endtask

    task automatic finish_test(input string name, input int base);
        int waited;
        waited = 0;
        while (n_pending != 0 && waited < 1000) begin
            @(posedge clk);
            #10;
            waited++;
        end
        if (n_pending != 0) begin
            $display("%s: %0d expected responses never arrived", name, n_pending);
            lost += n_pending;
        end
        $display("%s: %0d errors, %0d responses checked so far", name,
                 total_errors() - base, n_checked);
    endtask

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks failed");
        $finish;
    end

    initial begin
        word_t [NUM_THREADS-1:0] a;
        word_t [NUM_THREADS-1:0] b;
        int                      base;
        int                      overtaken_base;
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        push      = 1'b0;
        push_rsp  = '0;
        bp_en     = 1'b0;
        repeat (8) @(posedge clk);
        #10;
        rst = 1'b0;

        base = total_errors();
        repeat (20) begin
            fill(a, '0, 1'b0);
            fill(b, '0, 1'b0);
            send(MUL, a, b);
        end
        finish_test("test 1 mul low word", base);

        base = total_errors();
        for (int k = 0; k < 8; k++) begin
            fill(a, (k >= 6) ? 32'h8000_0000 : '0, 1'b0);   // the last two force negatives
            fill(b, (k >= 6) ? 32'h8000_0000 : '0, 1'b0);
            send(MULH, a, b);
            send(MULHSU, a, b);
            send(MULHU, a, b);
        end
        finish_test("test 2 mul high word", base);

        base = total_errors();
        for (int k = 0; k < 5; k++) begin
            fill(a, '0, 1'b0);
            fill(b, '0, k < 2);
            if (k == 4) begin
                a[0] = 32'h8000_0000;
                b[0] = '1;
                b[1] = '0;
                a[2] = 32'h8000_0000;
                b[2] = 32'h1;
                a[3] = '0;
                b[3] = '0;
            end
            for (int j = 0; j < 4; j++) begin
                send(muldiv_op_t'(4 + j), a, b);
            end
        end
        finish_test("test 3 divide and remainder", base);

        base  = total_errors();
        bp_en = 1'b1;
        repeat (30) begin
            fill(a, '0, 1'b0);
            fill(b, '0, 1'($random(seed)));
            send(muldiv_op_t'($random(seed) & 7), a, b);
        end
        bp_en = 1'b0;
        finish_test("test 4 random back-pressure", base);

        base           = total_errors();
        overtaken_base = n_overtaken;
        repeat (4) begin
            fill(a, '0, 1'b0);
            fill(b, '0, 1'b1);
            send(muldiv_op_t'(4 + ($random(seed) & 3)), a, b);
            repeat (3) begin
                fill(a, '0, 1'b0);
                fill(b, '0, 1'b0);
                send(muldiv_op_t'($random(seed) & 3), a, b);   // overtakes the divide
            end
        end
        finish_test("test 5 multiply during divide", base);
        if (n_overtaken - overtaken_base < 4) begin
            $display("test 5: only %0d of the 4 divides were overtaken by a later multiply",
                     n_overtaken - overtaken_base);
            order_errors++;
        end

        $display("%0d checked, %0d mismatches, %0d missing, %0d order errors, %0d failed asserts",
                 n_checked, n_errors, lost, order_errors,
                 i_muldiv_unit.i_muldiv_assertions.failures);
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* all.f */
muldiv_cfg_pkg.sv
muldiv_types_pkg.sv
mul_pipe.sv
serial_div.sv
rsp_arbiter.sv
muldiv_unit.sv
muldiv_assertions.sv
muldiv_checker.sv
tb_muldiv.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --no-stop-fail -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_muldiv -f all.f

run: compile
	@out="$$(./obj_dir/Vtb_muldiv)"; echo "$$out"; \
		echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
